/* build.f */
rtl/pipe_pkg.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/pipe_reg.sv
rtl/ex_stage.sv
rtl/pipe_ctrl.sv
rtl/int_pipe_top.sv
dv/tb_clk_gen.sv
dv/int_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= int_pipe_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/int_pipe_tb.sv */
module int_pipe_tb;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wreg;
        logic        known;
        logic [31:0] data;
        logic [31:0] acc_cyc;
    } shadow_t;

    logic clk, rstn, in_valid, in_ready, kill, out_valid, out_ready, out_wreg;
    logic [31:0] in_inst, out_pc, out_data;
    logic [4:0] out_rd;
    logic [31:0] rng = 32'd71;
    logic [31:0] model_rf [0:31];
    logic [31:0] next_pc, cyc;
    logic [31:0] prev_pc, prev_data;
    logic [4:0] prev_rd;
    logic prev_wreg, hold_prev, lat_check, first_ret;
    logic timed_out;
    shadow_t shadow;
    shadow_t exp_q[$];
    int checks, errors, total_errors, total_checks, kills, remaining;
    int gap_pct, stall_pct, kill_pct;

    tb_clk_gen clk_gen_i (.clk(clk), .rstn(rstn));

    int_pipe_top dut_i (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
        .kill(kill), .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_rd(out_rd), .out_wreg(out_wreg), .out_data(out_data)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r, r2;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        logic alt;
        r = next_rand();
        r2 = next_rand();
        rd = {2'b0, r[5:3]};                       // Few registers, so dependencies are common.
        rs1 = {2'b0, r[8:6]};
        rs2 = {2'b0, r[11:9]};
        f3 = r[14:12];
        imm = r[26:15];
        alt = r[27] && (f3 == 3'b000 || f3 == 3'b101);
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            3'd3, 3'd4, 3'd5: begin
                if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
                if (f3 == 3'b101) imm = {1'b0, r[27], 5'b0, imm[4:0]};
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            3'd6: return {r2[31:12], rd, 7'b0110111};
            default: return {r2[31:7], 7'b1110011};
        endcase
    endfunction

    // Reference semantics of the RV32I OP, OP-IMM and LUI classes.
    function automatic logic [31:0] ref_result(input logic [31:0] inst, input logic [31:0] a,
                                               input logic [31:0] b_reg);
        logic [31:0] b;
        logic [2:0] f3;
        logic alt;
        f3 = inst[14:12];
        if (inst[6:0] == 7'b0110111) return {inst[31:12], 12'b0};
        b = (inst[6:0] == 7'b0010011) ? {{20{inst[31]}}, inst[31:20]} : b_reg;
        alt = inst[30] && (inst[6:0] == 7'b0110011 || f3 == 3'b101);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Check failed at cycle %0d: %s", cyc, what);
            errors++;
        end
    endtask

    task automatic retire_check();
        shadow_t e;
        if (exp_q.size() == 0) begin
            check_true(1'b0, "a record retired with nothing expected");
            return;
        end
        e = exp_q.pop_front();
        if (first_ret) check_val("out_pc", out_pc, 32'h0);    // First PC after reset.
        first_ret = 1'b0;
        check_val("out_pc", out_pc, e.pc);
        check_val("out_rd", {27'b0, out_rd}, {27'b0, e.rd});
        check_val("out_wreg", {31'b0, out_wreg}, {31'b0, e.wreg});
        if (e.known) check_val("out_data", out_data, e.data);
        if (lat_check) check_val("latency", cyc - e.acc_cyc, 32'd2);
    endtask

    // Leaving ID/EX means the record will retire, so the model commits it here.
    task automatic advance_shadow();
        if (shadow.valid) begin
            exp_q.push_back(shadow);
            if (shadow.wreg && shadow.rd != 5'd0) model_rf[shadow.rd] = shadow.data;
        end
        shadow.valid = 1'b0;
    endtask

    task automatic step();
        logic acc, hs, ex_stall;
        @(posedge clk);
        cyc++;
        acc = in_valid && in_ready;
        hs = out_valid && out_ready;
        ex_stall = out_valid && !out_ready;
        if (hold_prev) begin
            check_val("out_pc", out_pc, prev_pc);
            check_val("out_data", out_data, prev_data);
            check_val("out_rd", {27'b0, out_rd}, {27'b0, prev_rd});
            check_val("out_wreg", {31'b0, out_wreg}, {31'b0, prev_wreg});
        end
        if (ex_stall) check_true(!in_ready, "in_ready high while the output is blocked");
        if (kill) check_true(!in_ready, "in_ready high during kill");
        hold_prev = ex_stall;
        prev_pc = out_pc;
        prev_data = out_data;
        prev_rd = out_rd;
        prev_wreg = out_wreg;
        if (hs) retire_check();
        if (kill) begin
            if (shadow.valid) kills++;
            shadow.valid = 1'b0;
        end else if (acc || !ex_stall) begin
            advance_shadow();
        end
        if (acc) begin
            shadow.valid = 1'b1;
            shadow.pc = next_pc;
            shadow.rd = in_inst[11:7];
            shadow.known = (in_inst[6:0] == 7'b0110011 || in_inst[6:0] == 7'b0010011 ||
                            in_inst[6:0] == 7'b0110111);
            shadow.wreg = shadow.known;
            shadow.data = ref_result(in_inst, model_rf[in_inst[19:15]], model_rf[in_inst[24:20]]);
            shadow.acc_cyc = cyc;
            next_pc = next_pc + 32'd4;
        end
        if (acc || !in_valid) begin
            if (remaining > 0 && (next_rand() % 100) >= gap_pct) begin
                in_valid <= 1'b1;
                in_inst <= gen_inst();
                remaining--;
            end else begin
                in_valid <= 1'b0;
            end
        end
        out_ready <= (next_rand() % 100) >= stall_pct;
        kill <= remaining > 0 && (next_rand() % 100) < kill_pct;
    endtask

    task automatic run_test(input string name, input int n, input int gap, input int stl,
                            input int kl, input logic lat);
        int timeout;
        if (timed_out) begin
            return;
        end
        checks = 0;
        errors = 0;
        kills = 0;
        remaining = n;
        gap_pct = gap;
        stall_pct = stl;
        kill_pct = kl;
        lat_check = lat;
        timeout = 0;
        step();
        while ((remaining > 0 || in_valid || kill || shadow.valid || exp_q.size() != 0 ||
                out_valid) && timeout <= 20000) begin
            step();
            timeout++;
        end
        if (timeout > 20000) begin
            $display("Timeout: test %s did not drain its instructions", name);
            timed_out = 1'b1;
        end else begin
            $display("test %s: %0d instructions, %0d kills, %0d checks, %0d errors",
                     name, n, kills, checks, errors);
        end
        total_checks += checks;
        total_errors += errors;
    endtask

    initial begin
        int timeout;
        in_valid = 1'b0;
        in_inst = 32'h0;
        kill = 1'b0;
        out_ready = 1'b1;
        shadow = '0;
        next_pc = 32'h0;
        cyc = 0;
        hold_prev = 1'b0;
        first_ret = 1'b1;
        timed_out = 1'b0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 32; i++) model_rf[i] = 32'h0;
        timeout = 0;
        while (rstn !== 1'b1 && timeout <= 20) begin
            @(posedge clk);
            timeout++;
        end
        if (rstn !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            checks = 0;
            errors = 0;
            repeat (3) begin
                @(posedge clk);
                check_val("out_valid", {31'b0, out_valid}, 32'h0);
            end
            $display("test %s: %0d checks, %0d errors", "reset", checks, errors);
            total_checks += checks;
            total_errors += errors;
        end
        run_test("continuous", 40, 0, 0, 0, 1'b1);
        run_test("random_mix", 300, 20, 15, 0, 1'b0);
        run_test("backpressure", 200, 10, 60, 0, 1'b0);
        run_test("kill", 300, 15, 20, 12, 1'b0);
        $display("Summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // Period of 8.
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

/* rtl/int_pipe_top.sv */
module int_pipe_top (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            in_valid,
    input  logic [pipe_pkg::xlen-1:0]       in_inst,
    output logic                            in_ready,
    input  logic                            kill,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [pipe_pkg::xlen-1:0]       out_pc,
    output logic [pipe_pkg::reg_addr_w-1:0] out_rd,
    output logic                            out_wreg,
    output logic [pipe_pkg::xlen-1:0]       out_data
);

    logic [pipe_pkg::stage_num-1:0]  stall;
    logic [pipe_pkg::stage_num-1:0]  ret_stall;
    pipe_pkg::id_ex_t                id_rec;
    pipe_pkg::id_ex_t                id_ex_q;
    pipe_pkg::ex_ret_t               ex_rec;
    pipe_pkg::ex_ret_t               ret_q;
    logic [pipe_pkg::xlen-1:0]       ex_fwd_data;
    logic [pipe_pkg::reg_addr_w-1:0] rs1_addr;
    logic [pipe_pkg::reg_addr_w-1:0] rs2_addr;
    logic [pipe_pkg::xlen-1:0]       rs1_val;
    logic [pipe_pkg::xlen-1:0]       rs2_val;
    logic                            rf_we;

    // EX counts as stopped during kill, so the killed record drains as a bubble.
    assign ret_stall[pipe_pkg::id_stage_bit] = stall[pipe_pkg::ex_stage_bit] || kill;
    assign ret_stall[pipe_pkg::ex_stage_bit] = stall[pipe_pkg::ex_stage_bit];

    assign rf_we = ret_q.valid && ret_q.wreg && out_ready;    // Written as it leaves.

    pipe_ctrl pipe_ctrl_i (
        .clk(clk), .rstn(rstn),
        .in_valid(in_valid), .kill(kill), .out_ready(out_ready),
        .ret_valid(ret_q.valid), .stall(stall), .in_ready(in_ready)
    );

    regfile regfile_i (
        .clk(clk), .rstn(rstn),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .we(rf_we), .wr_addr(ret_q.rd), .wr_data(ret_q.data)
    );

    id_stage id_stage_i (
        .clk(clk), .rstn(rstn), .inst(in_inst), .stall(stall), .id_ex(id_rec),
        .ex_fwd_data(ex_fwd_data), .ex_fwd(id_ex_q), .ret_fwd(ret_q),
        .rf_rs1_addr(rs1_addr), .rf_rs2_addr(rs2_addr),
        .rf_rs1_val(rs1_val), .rf_rs2_val(rs2_val)
    );

    pipe_reg #(.payload_t(pipe_pkg::id_ex_t), .nop_value(pipe_pkg::id_ex_nop)) id_ex_reg_i (
        .clk(clk), .rstn(rstn), .stall(stall), .flush(kill), .d(id_rec), .q(id_ex_q)
    );

    ex_stage ex_stage_i (
        .id_ex(id_ex_q), .ret(ex_rec), .fwd_data(ex_fwd_data)
    );

    pipe_reg #(.payload_t(pipe_pkg::ex_ret_t), .nop_value(pipe_pkg::ex_ret_nop)) ex_ret_reg_i (
        .clk(clk), .rstn(rstn), .stall(ret_stall), .flush(1'b0), .d(ex_rec), .q(ret_q)
    );

    assign out_valid = ret_q.valid;
    assign out_pc = ret_q.pc;
    assign out_rd = ret_q.rd;
    assign out_wreg = ret_q.wreg;
    assign out_data = ret_q.data;

endmodule

/* rtl/pipe_ctrl.sv */
module pipe_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           in_valid,
    input  logic                           kill,
    input  logic                           out_ready,
    input  logic                           ret_valid,
    output logic [pipe_pkg::stage_num-1:0] stall,
    output logic                           in_ready
);

    // Retire output is blocked, so everything behind it must wait.
    assign stall[pipe_pkg::ex_stage_bit] = ret_valid && !out_ready;

    // Kill also stops decode so the PC does not move on a refused instruction.
    assign stall[pipe_pkg::id_stage_bit] = stall[pipe_pkg::ex_stage_bit] || !in_valid || kill;

    assign in_ready = !stall[pipe_pkg::ex_stage_bit] && !kill;

    no_accept_on_kill: assert property (
        @(posedge clk) disable iff (!rstn)
        kill |-> !in_ready
    ) else $error("pipe_ctrl: in_ready high during kill");

    ex_stall_stops_id: assert property (
        @(posedge clk) disable iff (!rstn)
        stall[pipe_pkg::ex_stage_bit] |-> stall[pipe_pkg::id_stage_bit]
    ) else $error("pipe_ctrl: EX stalled while ID runs");

endmodule

/* rtl/ex_stage.sv */
module ex_stage (
    input  pipe_pkg::id_ex_t          id_ex,
    output pipe_pkg::ex_ret_t         ret,
    output logic [pipe_pkg::xlen-1:0] fwd_data
);

    logic [pipe_pkg::xlen-1:0] op_a;
    logic [pipe_pkg::xlen-1:0] op_b;
    logic [4:0]                shamt;
    logic [pipe_pkg::xlen-1:0] result;

    assign op_a = id_ex.rs1_val;
    assign op_b = id_ex.src2_imm ? id_ex.imm : id_ex.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            pipe_pkg::alu_add:    result = op_a + op_b;
            pipe_pkg::alu_sub:    result = op_a - op_b;
            pipe_pkg::alu_sll:    result = op_a << shamt;
            pipe_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            pipe_pkg::alu_sltu:   result = {31'b0, op_a < op_b};
            pipe_pkg::alu_xor:    result = op_a ^ op_b;
            pipe_pkg::alu_srl:    result = op_a >> shamt;
            pipe_pkg::alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            pipe_pkg::alu_or:     result = op_a | op_b;
            pipe_pkg::alu_and:    result = op_a & op_b;
            pipe_pkg::alu_pass_b: result = op_b;
            default:              result = '0;
        endcase
    end

    always_comb begin
        ret.valid = id_ex.valid;
        ret.pc = id_ex.pc;
        ret.rd = id_ex.rd;
        ret.wreg = id_ex.wreg;
        ret.data = result;
    end

    assign fwd_data = result;                      // Feeds decode before the retire register.

endmodule

/* rtl/pipe_reg.sv */
module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t nop_value = payload_t'(0)
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [pipe_pkg::stage_num-1:0] stall,
    input  logic                           flush,
    input  payload_t                       d,
    output payload_t                       q
);

    logic up_stop;
    logic own_stop;

    // The upstream stage sits in the ID bit and this register's own stage in the EX bit.
    assign up_stop = stall[pipe_pkg::id_stage_bit];
    assign own_stop = stall[pipe_pkg::ex_stage_bit];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            q <= nop_value;
        end else if (flush || (up_stop && !own_stop)) begin
            q <= nop_value;                        // Drained downstream, nothing new to take.
        end else if (!up_stop) begin
            q <= d;
        end
    end

    hold_when_stopped: assert property (
        @(posedge clk) disable iff (!rstn)
        (up_stop && own_stop && !flush) |=> $stable(q)
    ) else $error("pipe_reg: contents changed while both stages were stopped");

endmodule

/* rtl/id_stage.sv */
module id_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [pipe_pkg::xlen-1:0]       inst,
    input  logic [pipe_pkg::stage_num-1:0]  stall,
    output pipe_pkg::id_ex_t                id_ex,
    input  logic [pipe_pkg::xlen-1:0]       ex_fwd_data,
    input  pipe_pkg::id_ex_t                ex_fwd,
    input  pipe_pkg::ex_ret_t               ret_fwd,
    output logic [pipe_pkg::reg_addr_w-1:0] rf_rs1_addr,
    output logic [pipe_pkg::reg_addr_w-1:0] rf_rs2_addr,
    input  logic [pipe_pkg::xlen-1:0]       rf_rs1_val,
    input  logic [pipe_pkg::xlen-1:0]       rf_rs2_val
);

    logic [pipe_pkg::xlen-1:0] pc;
    logic [6:0]                opcode;
    logic [2:0]                funct3;

    // alt is funct7 bit 5, which picks SUB and SRA.
    function automatic pipe_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
            3'b001:  return pipe_pkg::alu_sll;
            3'b010:  return pipe_pkg::alu_slt;
            3'b011:  return pipe_pkg::alu_sltu;
            3'b100:  return pipe_pkg::alu_xor;
            3'b101:  return alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
            3'b110:  return pipe_pkg::alu_or;
            default: return pipe_pkg::alu_and;
        endcase
    endfunction

    function automatic logic [pipe_pkg::xlen-1:0] bypass(
        input logic [pipe_pkg::reg_addr_w-1:0] addr,
        input logic [pipe_pkg::xlen-1:0]       rf_val,
        input pipe_pkg::id_ex_t                ex_rec,
        input logic [pipe_pkg::xlen-1:0]       ex_val,
        input pipe_pkg::ex_ret_t               ret_rec
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex_rec.valid && ex_rec.wreg && ex_rec.rd == addr) begin
            return ex_val;                         // Youngest producer wins.
        end
        if (ret_rec.valid && ret_rec.wreg && ret_rec.rd == addr) begin
            return ret_rec.data;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= pipe_pkg::reset_pc;
        end else if (!stall[pipe_pkg::id_stage_bit]) begin
            pc <= pc + 32'd4;                      // Advances once per accepted instruction.
        end
    end

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rf_rs1_addr = inst[19:15];
    assign rf_rs2_addr = inst[24:20];

    always_comb begin
        id_ex = pipe_pkg::id_ex_nop;
        id_ex.valid = 1'b1;
        id_ex.pc = pc;
        id_ex.rd = inst[11:7];
        case (opcode)
            pipe_pkg::opc_op: begin
                id_ex.alu_op = alu_decode(funct3, inst[30]);
                id_ex.wreg = 1'b1;
            end
            pipe_pkg::opc_op_imm: begin
                id_ex.alu_op = alu_decode(funct3, inst[30] && funct3 == 3'b101);
                id_ex.imm = {{20{inst[31]}}, inst[31:20]};
                id_ex.src2_imm = 1'b1;
                id_ex.wreg = 1'b1;
            end
            pipe_pkg::opc_lui: begin
                id_ex.alu_op = pipe_pkg::alu_pass_b;
                id_ex.imm = {inst[31:12], 12'b0};
                id_ex.src2_imm = 1'b1;
                id_ex.wreg = 1'b1;
            end
            default: begin
                id_ex.wreg = 1'b0;                 // Unknown opcodes retire without a write.
            end
        endcase
        id_ex.rs1_val = bypass(rf_rs1_addr, rf_rs1_val, ex_fwd, ex_fwd_data, ret_fwd);
        id_ex.rs2_val = bypass(rf_rs2_addr, rf_rs2_val, ex_fwd, ex_fwd_data, ret_fwd);
    end

endmodule

/* rtl/regfile.sv */
module regfile (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [pipe_pkg::xlen-1:0]       rs1_val,
    output logic [pipe_pkg::xlen-1:0]       rs2_val,
    input  logic                            we,
    input  logic [pipe_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [pipe_pkg::xlen-1:0]       wr_data
);

    logic [pipe_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin   // Entry 0 is never written.
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 stays zero in storage, so the read path needs no special case.
    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    x0_write_ignored: assert property (
        @(posedge clk) disable iff (!rstn)
        (we && wr_addr == '0) |=> (regs[0] == '0)
    ) else $error("regfile: write to x0 changed its value");

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam int stage_num = 2;
    localparam int id_stage_bit = 0;
    localparam int ex_stage_bit = 1;

    localparam logic [xlen-1:0] reset_pc = '0;

    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b                          // LUI result is the immediate itself.
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic                  src2_imm;    // Operand 2 comes from imm instead of rs2.
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [reg_addr_w-1:0] rd;
        logic                  wreg;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wreg;
        logic [xlen-1:0]       data;
    } ex_ret_t;

    localparam id_ex_t id_ex_nop = '{
        valid:    1'b0,
        pc:       '0,
        alu_op:   alu_add,
        src2_imm: 1'b0,
        imm:      '0,
        rs1_val:  '0,
        rs2_val:  '0,
        rd:       '0,
        wreg:     1'b0
    };

    localparam ex_ret_t ex_ret_nop = '{
        valid: 1'b0,
        pc:    '0,
        rd:    '0,
        wreg:  1'b0,
        data:  '0
    };

endpackage
